/* logic/epu_pkg.sv */
// Shared MSR map for the exception unit; only PSR, IMR and IRR exist, all other addresses are unmapped
package epu_pkg;

   // MSR address width
   localparam int msr_addr_w = 4;

   // One MSR address on the access bus
   typedef logic [msr_addr_w-1:0] msr_addr_t;

   // Address map
   // Processor status register
   localparam msr_addr_t MSR_PSR = msr_addr_t'(0);

   // Interrupt mask register, one bit per line, 1 masks
   localparam msr_addr_t MSR_IMR = msr_addr_t'(1);

   // Interrupt request register, read only
   localparam msr_addr_t MSR_IRR = msr_addr_t'(2);

   // PSR layout
   // Interrupt enable, the only stored PSR bit
   // All other PSR bits read as zero
   localparam int PSR_IRE_BIT = 0;

endpackage

/* logic/msr_bus_arbiter.sv */
// Two-master round-robin MSR arbiter; one transaction in flight, so a new grant waits for the response handshake
`timescale 1ns/1ps

module msr_bus_arbiter #(
   parameter int DATA_W = 32
) (
   input  logic                  clk,
   input  logic                  arst_n,
   // Master 0, execute stage
   input  logic                  m0_req_valid,
   output logic                  m0_req_ready,
   input  logic                  m0_req_we,
   input  epu_pkg::msr_addr_t    m0_req_addr,
   input  logic [DATA_W-1:0]     m0_req_wdata,
   output logic                  m0_rsp_valid,
   input  logic                  m0_rsp_ready,
   output logic [DATA_W-1:0]     m0_rsp_rdata,
   output logic                  m0_rsp_err,
   // Master 1, debug port
   input  logic                  m1_req_valid,
   output logic                  m1_req_ready,
   input  logic                  m1_req_we,
   input  epu_pkg::msr_addr_t    m1_req_addr,
   input  logic [DATA_W-1:0]     m1_req_wdata,
   output logic                  m1_rsp_valid,
   input  logic                  m1_rsp_ready,
   output logic [DATA_W-1:0]     m1_rsp_rdata,
   output logic                  m1_rsp_err,
   // Shared slave bus
   output logic                  s_req_valid,
   input  logic                  s_req_ready,
   output logic                  s_req_we,
   output epu_pkg::msr_addr_t    s_req_addr,
   output logic [DATA_W-1:0]     s_req_wdata,
   input  logic                  s_rsp_valid,
   output logic                  s_rsp_ready,
   input  logic [DATA_W-1:0]     s_rsp_rdata,
   input  logic                  s_rsp_err
);

   // Transaction outstanding
   logic busy_q;
   // Master that owns the outstanding transaction
   logic owner_q;
   // Master granted most recently, reset to 1 so master 0 wins first tie
   logic last_q;
   // Selected master while idle
   logic grant;
   logic req_fire;
   logic rsp_fire;

   // On a tie pick the master that did not win last time
   // Otherwise whichever one is asking
   assign grant = (m0_req_valid & m1_req_valid) ? ~last_q : m1_req_valid;

   // Request path, open only while idle
   assign s_req_valid = ~busy_q & (m0_req_valid | m1_req_valid);
   assign s_req_we    = grant ? m1_req_we    : m0_req_we;
   assign s_req_addr  = grant ? m1_req_addr  : m0_req_addr;
   assign s_req_wdata = grant ? m1_req_wdata : m0_req_wdata;

   // Ready only to the granted, requesting master
   assign m0_req_ready = ~busy_q & m0_req_valid & ~grant & s_req_ready;
   assign m1_req_ready = ~busy_q & m1_req_valid &  grant & s_req_ready;

   assign req_fire = s_req_valid & s_req_ready;

   // Response path, steered by owner
   assign s_rsp_ready = busy_q & (owner_q ? m1_rsp_ready : m0_rsp_ready);

   assign m0_rsp_valid = busy_q & ~owner_q & s_rsp_valid;
   assign m1_rsp_valid = busy_q &  owner_q & s_rsp_valid;

   // Data zeroed towards the master that does not own the response
   assign m0_rsp_rdata = m0_rsp_valid ? s_rsp_rdata : '0;
   assign m1_rsp_rdata = m1_rsp_valid ? s_rsp_rdata : '0;
   assign m0_rsp_err   = m0_rsp_valid & s_rsp_err;
   assign m1_rsp_err   = m1_rsp_valid & s_rsp_err;

   assign rsp_fire = s_rsp_valid & s_rsp_ready;

   // Busy from request accept until response handshake
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy_q  <= 1'b0;
         owner_q <= 1'b0;
         last_q  <= 1'b1;
      end else if (req_fire) begin
         busy_q  <= 1'b1;
         owner_q <= grant;
         last_q  <= grant;
      end else if (rsp_fire) begin
         // Bus free again, next grant one cycle later
         busy_q  <= 1'b0;
      end
   end

endmodule

/* logic/msr_regfile.sv */
// MSR slave with one registered response per request; IRR writes are dropped and unmapped addresses return zero with err
`timescale 1ns/1ps

module msr_regfile #(
   parameter int DATA_W  = 32,
   parameter int NUM_IRQ = 8
) (
   input  logic                  clk,
   input  logic                  arst_n,
   // Request
   input  logic                  s_req_valid,
   output logic                  s_req_ready,
   input  logic                  s_req_we,
   input  epu_pkg::msr_addr_t    s_req_addr,
   input  logic [DATA_W-1:0]     s_req_wdata,
   // Response
   output logic                  s_rsp_valid,
   input  logic                  s_rsp_ready,
   output logic [DATA_W-1:0]     s_rsp_rdata,
   output logic                  s_rsp_err,
   // Interrupt controller side
   output logic                  psr_ire,
   output logic                  imr_we,
   output logic [DATA_W-1:0]     imr_nxt,
   input  logic [DATA_W-1:0]     imr,
   input  logic [DATA_W-1:0]     irr
);

   import epu_pkg::*;

   // Lines that exist, upper IRR bits read zero
   localparam logic [DATA_W-1:0] IRQ_LINE_MASK = ~({DATA_W{1'b1}} << NUM_IRQ);

   // Stored interrupt enable
   logic              psr_ire_q;
   // Response holding registers
   logic              rsp_valid_q;
   logic [DATA_W-1:0] rsp_rdata_q;
   logic              rsp_err_q;
   // Decode results
   logic              req_fire;
   logic              rsp_fire;
   logic              sel_psr;
   logic              sel_imr;
   logic              sel_irr;
   logic              addr_hit;
   logic [DATA_W-1:0] psr_word;
   logic [DATA_W-1:0] rd_data;
   logic [DATA_W-1:0] rsp_data_nxt;

   // No new request while a response is waiting
   assign s_req_ready = ~rsp_valid_q;

   assign req_fire = s_req_valid & s_req_ready;
   assign rsp_fire = rsp_valid_q & s_rsp_ready;

   // Address decode
   assign sel_psr  = (s_req_addr == MSR_PSR);
   assign sel_imr  = (s_req_addr == MSR_IMR);
   assign sel_irr  = (s_req_addr == MSR_IRR);
   assign addr_hit = sel_psr | sel_imr | sel_irr;

   // PSR image, only IRE is backed by a flop
   always_comb begin
      psr_word = '0;
      psr_word[PSR_IRE_BIT] = psr_ire_q;
   end

   // Read mux
   always_comb begin
      rd_data = '0;
      if (sel_psr) begin
         rd_data = psr_word;
      end else if (sel_imr) begin
         rd_data = imr;
      end else if (sel_irr) begin
         rd_data = irr & IRQ_LINE_MASK;
      end
   end

   // Writes echo their data, unmapped always zero
   assign rsp_data_nxt = !addr_hit ? '0 :
                         s_req_we  ? s_req_wdata : rd_data;

   // IMR lives in the controller, one-cycle load strobe
   assign imr_we  = req_fire & s_req_we & sel_imr;
   assign imr_nxt = s_req_wdata;

   // PSR IRE, written at the accepting edge
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         psr_ire_q <= 1'b0;
      end else if (req_fire && s_req_we && sel_psr) begin
         psr_ire_q <= s_req_wdata[PSR_IRE_BIT];
      end
   end

   // Response valid, set on accept and cleared on handshake
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rsp_valid_q <= 1'b0;
      end else if (req_fire) begin
         rsp_valid_q <= 1'b1;
      end else if (rsp_fire) begin
         rsp_valid_q <= 1'b0;
      end
   end

   // Payload captured once, held under back-pressure
   always_ff @(posedge clk) begin
      if (req_fire) begin
         rsp_rdata_q <= rsp_data_nxt;
         rsp_err_q   <= ~addr_hit;
      end
   end

   assign s_rsp_valid = rsp_valid_q;
   assign s_rsp_rdata = rsp_rdata_q;
   assign s_rsp_err   = rsp_err_q;
   assign psr_ire     = psr_ire_q;

endmodule

/* logic/epu_irqc.sv */
// Level-sensitive interrupt controller; irqs must be levels held at least 2 clocks, NUM_IRQ must not exceed DATA_W
`timescale 1ns/1ps

module epu_irqc #(
   parameter int DATA_W  = 32,
   parameter int NUM_IRQ = 8
) (
   input  logic                                            clk,
   input  logic                                            arst_n,
   input  logic [NUM_IRQ-1:0]                              irqs,
   input  logic                                            psr_ire,
   // IMR write from the register file
   input  logic                                            imr_we,
   input  logic [DATA_W-1:0]                               imr_nxt,
   // Read views
   output logic [DATA_W-1:0]                               imr,
   output logic [DATA_W-1:0]                               irr,
   // Request towards the exception unit
   output logic                                            irq_async,
   output logic [$clog2(NUM_IRQ > 1 ? NUM_IRQ : 2)-1:0]    irq_num
);

   localparam int IRQ_NUM_W = $clog2(NUM_IRQ > 1 ? NUM_IRQ : 2);

   // Two-flop synchronizer, second stage is IRR
   logic [NUM_IRQ-1:0] sync_q;
   logic [NUM_IRQ-1:0] irr_q;
   // Stored mask
   logic [DATA_W-1:0]  imr_q;
   // Pending and not masked
   logic [NUM_IRQ-1:0] irq_masked;

   // IRR just follows the line levels
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sync_q <= '0;
         irr_q  <= '0;
      end else begin
         sync_q <= irqs;
         irr_q  <= sync_q;
      end
   end

   // Everything masked out of reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         imr_q <= '1;
      end else if (imr_we) begin
         imr_q <= imr_nxt;
      end
   end

   // Bypass so the new mask acts in the write cycle
   assign imr = imr_we ? imr_nxt : imr_q;

   // Zero-extended to bus width
   assign irr = DATA_W'(irr_q);

   assign irq_masked = irr_q & ~imr[NUM_IRQ-1:0];

   // Gated by PSR interrupt enable
   assign irq_async = (|irq_masked) & psr_ire;

   // Lowest index wins
   // Scan downwards so the last hit is the lowest
   always_comb begin
      irq_num = '0;
      for (int i = NUM_IRQ - 1; i >= 0; i--) begin
         if (irq_masked[i]) begin
            irq_num = IRQ_NUM_W'(i);
         end
      end
   end

endmodule

/* logic/epu_irq_top.sv */
// Interrupt block top; NUM_IRQ must not exceed DATA_W, both masters see one outstanding MSR access at a time
`timescale 1ns/1ps

module epu_irq_top #(
   parameter int DATA_W  = 32,
   parameter int NUM_IRQ = 8
) (
   input  logic                                            clk,
   input  logic                                            arst_n,
   input  logic [NUM_IRQ-1:0]                              irqs,
   output logic                                            irq_async,
   output logic [$clog2(NUM_IRQ > 1 ? NUM_IRQ : 2)-1:0]    irq_num,
   // Master 0, execute stage
   input  logic                                            m0_req_valid,
   output logic                                            m0_req_ready,
   input  logic                                            m0_req_we,
   input  epu_pkg::msr_addr_t                              m0_req_addr,
   input  logic [DATA_W-1:0]                               m0_req_wdata,
   output logic                                            m0_rsp_valid,
   input  logic                                            m0_rsp_ready,
   output logic [DATA_W-1:0]                               m0_rsp_rdata,
   output logic                                            m0_rsp_err,
   // Master 1, debug port
   input  logic                                            m1_req_valid,
   output logic                                            m1_req_ready,
   input  logic                                            m1_req_we,
   input  epu_pkg::msr_addr_t                              m1_req_addr,
   input  logic [DATA_W-1:0]                               m1_req_wdata,
   output logic                                            m1_rsp_valid,
   input  logic                                            m1_rsp_ready,
   output logic [DATA_W-1:0]                               m1_rsp_rdata,
   output logic                                            m1_rsp_err
);

   import epu_pkg::*;

   // Arbiter to register file
   logic              s_req_valid;
   logic              s_req_ready;
   logic              s_req_we;
   msr_addr_t         s_req_addr;
   logic [DATA_W-1:0] s_req_wdata;
   logic              s_rsp_valid;
   logic              s_rsp_ready;
   logic [DATA_W-1:0] s_rsp_rdata;
   logic              s_rsp_err;
   // Register file to interrupt controller
   logic              psr_ire;
   logic              imr_we;
   logic [DATA_W-1:0] imr_nxt;
   logic [DATA_W-1:0] imr;
   logic [DATA_W-1:0] irr;

   msr_bus_arbiter #(.DATA_W(DATA_W)) u_arb (
      .clk          (clk),          .arst_n       (arst_n),
      .m0_req_valid (m0_req_valid), .m0_req_ready (m0_req_ready),
      .m0_req_we    (m0_req_we),    .m0_req_addr  (m0_req_addr),
      .m0_req_wdata (m0_req_wdata), .m0_rsp_valid (m0_rsp_valid),
      .m0_rsp_ready (m0_rsp_ready), .m0_rsp_rdata (m0_rsp_rdata),
      .m0_rsp_err   (m0_rsp_err),
      .m1_req_valid (m1_req_valid), .m1_req_ready (m1_req_ready),
      .m1_req_we    (m1_req_we),    .m1_req_addr  (m1_req_addr),
      .m1_req_wdata (m1_req_wdata), .m1_rsp_valid (m1_rsp_valid),
      .m1_rsp_ready (m1_rsp_ready), .m1_rsp_rdata (m1_rsp_rdata),
      .m1_rsp_err   (m1_rsp_err),
      .s_req_valid  (s_req_valid),  .s_req_ready  (s_req_ready),
      .s_req_we     (s_req_we),     .s_req_addr   (s_req_addr),
      .s_req_wdata  (s_req_wdata),  .s_rsp_valid  (s_rsp_valid),
      .s_rsp_ready  (s_rsp_ready),  .s_rsp_rdata  (s_rsp_rdata),
      .s_rsp_err    (s_rsp_err)
   );

   msr_regfile #(.DATA_W(DATA_W), .NUM_IRQ(NUM_IRQ)) u_msr (
      .clk         (clk),         .arst_n      (arst_n),
      .s_req_valid (s_req_valid), .s_req_ready (s_req_ready),
      .s_req_we    (s_req_we),    .s_req_addr  (s_req_addr),
      .s_req_wdata (s_req_wdata), .s_rsp_valid (s_rsp_valid),
      .s_rsp_ready (s_rsp_ready), .s_rsp_rdata (s_rsp_rdata),
      .s_rsp_err   (s_rsp_err),   .psr_ire     (psr_ire),
      .imr_we      (imr_we),      .imr_nxt     (imr_nxt),
      .imr         (imr),         .irr         (irr)
   );

   // Interrupt controller
   epu_irqc #(.DATA_W(DATA_W), .NUM_IRQ(NUM_IRQ)) u_irqc (
      .clk       (clk),       .arst_n    (arst_n),
      .irqs      (irqs),      .psr_ire   (psr_ire),
      .imr_we    (imr_we),    .imr_nxt   (imr_nxt),
      .imr       (imr),       .irr       (irr),
      .irq_async (irq_async), .irq_num   (irq_num)
   );

endmodule

/* verification/epu_irq_tb.sv */
// Run from the project root so the stim file path resolves; the run stops at the first error
`timescale 1ns/1ps

module epu_irq_tb;

   import epu_pkg::*;

   localparam int DATA_W    = 32;
   localparam int NUM_IRQ   = 8;
   localparam int IRQ_NUM_W = $clog2(NUM_IRQ > 1 ? NUM_IRQ : 2);

   logic                 clk;
   logic                 arst_n;
   logic [NUM_IRQ-1:0]   irqs;
   logic                 irq_async;
   logic [IRQ_NUM_W-1:0] irq_num;
   logic                 m0_req_valid, m0_req_ready, m0_req_we;
   msr_addr_t            m0_req_addr;
   logic [DATA_W-1:0]    m0_req_wdata, m0_rsp_rdata;
   logic                 m0_rsp_valid, m0_rsp_ready, m0_rsp_err;
   logic                 m1_req_valid, m1_req_ready, m1_req_we;
   msr_addr_t            m1_req_addr;
   logic [DATA_W-1:0]    m1_req_wdata, m1_rsp_rdata;
   logic                 m1_rsp_valid, m1_rsp_ready, m1_rsp_err;

   // Command table loaded from the stim file
   int                   cmd_op[$];
   int                   cmd_master[$];
   logic                 cmd_we[$];
   msr_addr_t            cmd_addr[$];
   logic [DATA_W-1:0]    cmd_wdata[$];
   int                   cmd_hold[$];
   logic [NUM_IRQ-1:0]   cmd_irqs[$];
   logic [DATA_W-1:0]    cmd_data[$];
   logic                 cmd_err[$];
   logic                 cmd_async[$];
   logic [IRQ_NUM_W-1:0] cmd_num[$];
   int                   n_cmd;
   logic                 loaded;
   // Idle gap generator state
   logic [7:0]           lfsr;

   epu_irq_top #(.DATA_W(DATA_W), .NUM_IRQ(NUM_IRQ)) uut (
      .clk          (clk),          .arst_n       (arst_n),
      .irqs         (irqs),         .irq_async    (irq_async),
      .irq_num      (irq_num),
      .m0_req_valid (m0_req_valid), .m0_req_ready (m0_req_ready),
      .m0_req_we    (m0_req_we),    .m0_req_addr  (m0_req_addr),
      .m0_req_wdata (m0_req_wdata), .m0_rsp_valid (m0_rsp_valid),
      .m0_rsp_ready (m0_rsp_ready), .m0_rsp_rdata (m0_rsp_rdata),
      .m0_rsp_err   (m0_rsp_err),
      .m1_req_valid (m1_req_valid), .m1_req_ready (m1_req_ready),
      .m1_req_we    (m1_req_we),    .m1_req_addr  (m1_req_addr),
      .m1_req_wdata (m1_req_wdata), .m1_rsp_valid (m1_rsp_valid),
      .m1_rsp_ready (m1_rsp_ready), .m1_rsp_rdata (m1_rsp_rdata),
      .m1_rsp_err   (m1_rsp_err)
   );

   // 40 ns clock
   always #20 clk = ~clk;

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped");
   endtask

   // Galois LFSR with taps x^8+x^6+x^5+x^4+1
   function automatic logic [7:0] lfsr_step(input logic [7:0] s);
      return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
   endfunction

   // Per-master views of the handshake outputs
   function automatic logic req_ready_of(input int m);
      return (m == 0) ? m0_req_ready : m1_req_ready;
   endfunction

   function automatic logic rsp_valid_of(input int m);
      return (m == 0) ? m0_rsp_valid : m1_rsp_valid;
   endfunction

   task automatic check_rsp(input int m, input logic [DATA_W-1:0] got_data,
                            input logic got_err, input logic [DATA_W-1:0] exp_data,
                            input logic exp_err);
      if (got_data !== exp_data)
         stop_on_error($sformatf("** Error: m%0d_rsp_rdata expected 0x%h, got 0x%h",
                                 m, exp_data, got_data));
      if (got_err !== exp_err)
         stop_on_error($sformatf("** Error: m%0d_rsp_err expected 0x%h, got 0x%h",
                                 m, exp_err, got_err));
   endtask

   task automatic check_irq(input logic got_async, input logic exp_async,
                            input logic [IRQ_NUM_W-1:0] got_num,
                            input logic [IRQ_NUM_W-1:0] exp_num);
      if (got_async !== exp_async)
         stop_on_error($sformatf("** Error: irq_async expected 0x%h, got 0x%h",
                                 exp_async, got_async));
      if (got_num !== exp_num)
         stop_on_error($sformatf("** Error: irq_num expected 0x%h, got 0x%h",
                                 exp_num, got_num));
   endtask

   // Response must sit at its own master and nowhere else
   task automatic check_delivery(input int m);
      if (!rsp_valid_of(m))
         stop_on_error($sformatf("Response for master %0d is missing", m));
      if (rsp_valid_of(1 - m))
         stop_on_error($sformatf("Response of master %0d showed up at master %0d", m, 1 - m));
   endtask

   // 0 to 3 idle cycles from two LFSR bits
   task automatic idle_gap();
      int n;
      n = 0;
      repeat (2) begin
         n = (n << 1) | lfsr[0];
         lfsr = lfsr_step(lfsr);
      end
      repeat (n) begin
         @(negedge clk);
         if (m0_rsp_valid || m1_rsp_valid)
            stop_on_error("Response valid without an outstanding request");
      end
      @(posedge clk);
   endtask

   // Called right after a rising edge
   task automatic start_cmd(input int i);
      if (cmd_master[i] == 0) begin
         m0_req_valid <= 1'b1;
         m0_req_we    <= cmd_we[i];
         m0_req_addr  <= cmd_addr[i];
         m0_req_wdata <= cmd_wdata[i];
         m0_rsp_ready <= (cmd_hold[i] == 0);
      end else begin
         m1_req_valid <= 1'b1;
         m1_req_we    <= cmd_we[i];
         m1_req_addr  <= cmd_addr[i];
         m1_req_wdata <= cmd_wdata[i];
         m1_rsp_ready <= (cmd_hold[i] == 0);
      end
   endtask

   // Waits for the handshake, then checks latency, hold and data
   task automatic complete_req(input int i);
      int m;
      m = cmd_master[i];
      @(negedge clk);
      while (!req_ready_of(m)) begin
         if (req_ready_of(1 - m))
            stop_on_error($sformatf("Request of master %0d accepted out of turn", 1 - m));
         @(negedge clk);
      end
      @(posedge clk);
      if (m == 0) m0_req_valid <= 1'b0;
      else m1_req_valid <= 1'b0;
      // One cycle after the handshake
      @(negedge clk);
      check_delivery(m);
      if (cmd_hold[i] > 0) begin
         repeat (cmd_hold[i]) begin
            check_rsp(m, m ? m1_rsp_rdata : m0_rsp_rdata, m ? m1_rsp_err : m0_rsp_err,
                      cmd_data[i], cmd_err[i]);
            if (req_ready_of(1 - m))
               stop_on_error($sformatf("Master %0d accepted while response held", 1 - m));
            @(negedge clk);
            check_delivery(m);
         end
         @(posedge clk);
         if (m == 0) m0_rsp_ready <= 1'b1;
         else m1_rsp_ready <= 1'b1;
         @(negedge clk);
         check_delivery(m);
      end
      check_rsp(m, m ? m1_rsp_rdata : m0_rsp_rdata, m ? m1_rsp_err : m0_rsp_err,
                cmd_data[i], cmd_err[i]);
   endtask

   // Levels need 2 cycles through the synchronizer plus one spare
   task automatic run_irq(input int i);
      @(posedge clk);
      irqs <= cmd_irqs[i];
      repeat (3) @(posedge clk);
      @(negedge clk);
      check_irq(irq_async, cmd_async[i], irq_num, cmd_num[i]);
   endtask

   task automatic load_stim();
      int    fd;
      int    cnt;
      int    f[11];
      string line;
      fd = $fopen("verification/epu_irq_stim.txt", "r");
      if (fd == 0) stop_on_error("Cannot open verification/epu_irq_stim.txt");
      while (!$feof(fd)) begin
         cnt = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h\n", f[0], f[1], f[2],
                       f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
         if (cnt == 11) begin
            cmd_op.push_back(f[0]);
            cmd_master.push_back(f[1]);
            cmd_we.push_back(f[2][0]);
            cmd_addr.push_back(msr_addr_t'(f[3]));
            cmd_wdata.push_back(DATA_W'(f[4]));
            cmd_hold.push_back(f[5]);
            cmd_irqs.push_back(NUM_IRQ'(f[6]));
            cmd_data.push_back(DATA_W'(f[7]));
            cmd_err.push_back(f[8][0]);
            cmd_async.push_back(f[9][0]);
            cmd_num.push_back(IRQ_NUM_W'(f[10]));
         end else begin
            // Comment lines are skipped up to their end
            void'($fgets(line, fd));
         end
      end
      $fclose(fd);
      n_cmd = cmd_op.size();
   endtask

   // Hang guard sized from the command count
   initial begin
      wait (loaded === 1'b1);
      repeat (n_cmd * 20 + 100) @(posedge clk);
      stop_on_error("Timeout, the DUT stopped answering and the run hung");
   end

   initial begin
      int i;
      clk          = 1'b0;
      arst_n       = 1'b0;
      irqs         = '0;
      m0_req_valid = 1'b0;
      m0_req_we    = 1'b0;
      m0_req_addr  = '0;
      m0_req_wdata = '0;
      m0_rsp_ready = 1'b0;
      m1_req_valid = 1'b0;
      m1_req_we    = 1'b0;
      m1_req_addr  = '0;
      m1_req_wdata = '0;
      m1_rsp_ready = 1'b0;
      lfsr         = 8'd94;
      loaded       = 1'b0;
      load_stim();
      loaded = 1'b1;
      repeat (8) @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);
      if (m0_req_ready || m1_req_ready || m0_rsp_valid || m1_rsp_valid)
         stop_on_error("Handshake output high right after reset");
      i = 0;
      while (i < n_cmd) begin
         if (cmd_op[i] == 0) begin
            idle_gap();
            start_cmd(i);
            complete_req(i);
            i++;
         end else if (cmd_op[i] == 1) begin
            run_irq(i);
            i++;
         end else begin
            // Both masters raise valid on the same edge and the first line must win
            if (i + 1 >= n_cmd) stop_on_error("Paired access line without its partner");
            idle_gap();
            start_cmd(i);
            start_cmd(i + 1);
            complete_req(i);
            complete_req(i + 1);
            i += 2;
         end
      end
      @(posedge clk);
      $display("NO ERRORS");
      $finish;
   end

endmodule

/* files.f */
logic/epu_pkg.sv
logic/msr_bus_arbiter.sv
logic/msr_regfile.sv
logic/epu_irqc.sv
logic/epu_irq_top.sv
verification/epu_irq_tb.sv

/* verification/epu_irq_stim.txt */
// op(0 access, 1 irq, 2 paired access) master we addr wdata hold irqs exp_data exp_err exp_async exp_num
// all hex; op 2 lines come in twos and the first of the two must win arbitration
1 0 0 0 00000000 0 00 00000000 0 0 0
0 0 0 0 00000000 0 00 00000000 0 0 0
0 1 0 1 00000000 0 00 ffffffff 0 0 0
0 0 0 2 00000000 0 00 00000000 0 0 0
0 1 1 0 ffffffff 0 00 ffffffff 0 0 0
0 0 0 0 00000000 0 00 00000001 0 0 0
0 0 1 0 00000000 0 00 00000000 0 0 0
0 1 0 0 00000000 0 00 00000000 0 0 0
0 1 1 1 000000f0 0 00 000000f0 0 0 0
0 0 0 1 00000000 0 00 000000f0 0 0 0
0 0 1 2 000000ff 0 00 000000ff 0 0 0
0 1 0 2 00000000 0 00 00000000 0 0 0
0 0 0 3 00000000 0 00 00000000 1 0 0
0 1 1 f 12345678 0 00 00000000 1 0 0
1 0 0 0 00000000 0 30 00000000 0 0 0
1 0 0 0 00000000 0 34 00000000 0 0 2
0 0 1 0 00000001 0 00 00000001 0 0 0
1 0 0 0 00000000 0 34 00000000 0 1 2
1 0 0 0 00000000 0 3c 00000000 0 1 2
1 0 0 0 00000000 0 38 00000000 0 1 3
0 1 0 2 00000000 0 00 00000038 0 0 0
0 0 1 1 00000000 0 00 00000000 0 0 0
1 0 0 0 00000000 0 38 00000000 0 1 3
1 0 0 0 00000000 0 a0 00000000 0 1 5
0 1 0 2 00000000 3 00 000000a0 0 0 0
1 0 0 0 00000000 0 00 00000000 0 0 0
0 0 0 2 00000000 0 00 00000000 0 0 0
2 1 1 1 0000005a 0 00 0000005a 0 0 0
2 0 1 1 000000a5 0 00 000000a5 0 0 0
2 1 0 1 00000000 4 00 000000a5 0 0 0
2 0 0 0 00000000 0 00 00000001 0 0 0
2 1 1 0 00000000 2 00 00000000 0 0 0
2 0 0 2 00000000 0 00 00000000 0 0 0
0 1 0 0 00000000 0 00 00000000 0 0 0
2 0 0 0 00000000 2 00 00000000 0 0 0
2 1 0 1 00000000 0 00 000000a5 0 0 0
1 0 0 0 00000000 0 5a 00000000 0 0 1
0 0 1 0 00000001 0 00 00000001 0 0 0
1 0 0 0 00000000 0 5a 00000000 0 1 1
1 0 0 0 00000000 0 25 00000000 0 0 0
